/* Bender.yml */
package:
  name: spi_master

sources:
  - files:
      - design/spi_pkg.sv
      - design/spi_clock_divider.sv
      - design/spi_shift_engine.sv
      - design/spi_wb_regs.sv
      - design/spi_master_top.sv
  - target: test
    files:
      - bench/spi_slave_model.sv
      - bench/spi_master_tb.sv

/* bench/spi_master_tb.sv */
`timescale 1ns/1ps

module spi_master_tb;

    // Expected outcome of one transfer
    typedef struct packed {
        logic [spi_pkg::word_width-1:0] mosi_word;
        logic [spi_pkg::word_width-1:0] rx_word;
        logic [spi_pkg::div_width:0]    half;
    } expect_t;

    localparam int rand_count = 20;

    logic                               clk;
    logic                               reset;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    spi_pkg::reg_addr_t                 wb_adr;
    logic [spi_pkg::wb_data_width-1:0]  wb_dat_w;
    logic [spi_pkg::wb_sel_width-1:0]   wb_sel;
    logic [spi_pkg::wb_data_width-1:0]  wb_dat_r;
    logic                               wb_ack;
    logic                               sclk;
    logic                               mosi;
    logic                               miso;
    logic                               cs;
    logic [spi_pkg::word_width-1:0]     slave_word;   // Preset reply of the slave
    logic [spi_pkg::word_width-1:0]     slave_seen;   // Word the slave captured
    logic [spi_pkg::word_width-1:0]     exp_tx;
    logic [spi_pkg::word_width-1:0]     got_rx;
    logic [spi_pkg::div_width-1:0]      cur_div;      // Divisor of the running transfer
    logic [31:0]                        rng;
    logic                               check_req;
    logic                               last_sclk;
    int                                 run_len;
    int                                 half_count;
    int                                 errors;
    int                                 checks;
    int                                 tests_run;
    int                                 tests_passed;
    int                                 cycles;
    int                                 limit;
    logic [spi_pkg::div_width-1:0]      rnd_div [rand_count];
    logic [spi_pkg::word_width-1:0]     rnd_tx [rand_count];
    logic [spi_pkg::word_width-1:0]     rnd_sw [rand_count];

    spi_master_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sclk     (sclk),
        .mosi     (mosi),
        .miso     (miso),
        .cs       (cs)
    );

    spi_slave_model slave0 (
        .sclk     (sclk),
        .cs       (cs),
        .mosi     (mosi),
        .miso     (miso),
        .preset   (slave_word),
        .captured (slave_seen)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Slave sees the TXDATA word while RXDATA gets the slave word
    function automatic expect_t ref_model(input logic [15:0] tx, input logic [15:0] sw,
                                          input logic [7:0] div);
        expect_t e;
        e.mosi_word = tx;
        e.rx_word   = sw;
        e.half      = {1'b0, div} + 1'b1;  // Clocks per sclk half period
        return e;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [7:0] div, input logic start);
        logic [31:0] w;
        w = '0;
        w[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width] = div;
        w[spi_pkg::ctrl_start_bit] = start;
        return w;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wb_write(input spi_pkg::reg_addr_t a, input logic [31:0] d);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= a;
        wb_dat_w <= d;
        do begin
            @(posedge clk);
        end while (wb_ack !== 1'b1);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input spi_pkg::reg_addr_t a, output logic [31:0] d);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= a;
        do begin
            @(posedge clk);
        end while (wb_ack !== 1'b1);
        d = wb_dat_r;  // Registered data valid with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic load_tx(input logic [15:0] tx);
        exp_tx = tx;
        wb_write(spi_pkg::reg_txdata, {16'h0, tx});
    endtask

    task automatic launch(input logic [15:0] sw, input logic [7:0] div);
        slave_word = sw;
        cur_div    = div;
        wb_write(spi_pkg::reg_ctrl, ctrl_word(div, 1'b1));
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        do begin
            wb_read(spi_pkg::reg_status, st);
        end while (st[spi_pkg::status_busy_bit]);
    endtask

    // Poll to the end, fetch RXDATA and hand the result to the compare process
    task automatic finish_transfer();
        logic [31:0] rx;
        wait_idle();
        wb_read(spi_pkg::reg_rxdata, rx);
        got_rx    = rx[15:0];
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %0d, %s: passed", tests_run, name);
        end else begin
            $display("test %0d, %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    always begin : compare_results
        expect_t e;
        wait (check_req);
        e = ref_model(exp_tx, slave_word, cur_div);
        expect_eq(slave_seen, e.mosi_word, "word captured by slave");
        expect_eq(got_rx, e.rx_word, "RXDATA");
        check_req = 1'b0;
    end

    // Length in system clocks of every sclk level while cs is low
    always @(posedge clk) begin : sclk_timing
        expect_t e;
        if (reset || cs) begin
            run_len   = 0;
            last_sclk = 1'b0;
        end else if (sclk !== last_sclk) begin
            e = ref_model(exp_tx, slave_word, cur_div);
            expect_eq(run_len, e.half, sclk ? "sclk low time" : "sclk high time");
            half_count++;
            run_len   = 1;
            last_sclk = sclk;
        end else begin
            run_len++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timed out after %0d clock cycles, transfers never finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : main
        logic [31:0] r;
        logic [31:0] d;
        logic [15:0] tx_a;
        int          mark;
        int          plan_div[$];
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = spi_pkg::reg_ctrl;
        wb_dat_w   = '0;
        wb_sel     = '1;
        slave_word = '0;
        exp_tx     = '0;
        got_rx     = '0;
        cur_div    = 8'd1;
        check_req  = 1'b0;
        half_count = 0;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        tests_passed = 0;
        cycles     = 0;
        rng        = 32'hc1f0;
        for (int i = 0; i < rand_count; i++) begin
            next_random(r);
            rnd_tx[i]  = r[15:0];
            rnd_sw[i]  = r[31:16];
            next_random(r);
            rnd_div[i] = 8'(r[1:0]) + 8'd1;  // Range 1 to 4
        end
        plan_div = '{2, 1, 3, 7, 3, 3, 2};
        foreach (rnd_div[i]) plan_div.push_back(int'(rnd_div[i]));
        limit = 200;
        foreach (plan_div[i]) limit += 34 * (plan_div[i] + 1) + 20;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        mark = errors;
        expect_eq(cs, 1'b1, "cs after reset");
        expect_eq(sclk, 1'b0, "sclk after reset");
        expect_eq(wb_ack, 1'b0, "ack after reset");
        wb_read(spi_pkg::reg_status, d);
        expect_eq(d, 32'h0, "STATUS after reset");
        wb_read(spi_pkg::reg_ctrl, d);
        expect_eq(d, ctrl_word(8'd1, 1'b0), "CTRL after reset");
        end_test("reset values", mark);

        mark = errors;
        next_random(r);
        load_tx(r[15:0]);
        launch(r[31:16], 8'd2);
        finish_transfer();
        end_test("single transfer, divisor 2", mark);

        mark = errors;
        for (int k = 0; k < 3; k++) begin
            next_random(r);
            load_tx(r[15:0]);
            half_count = 0;
            launch(r[31:16], 8'((2 << k) - 1));  // Divisors 1, 3, 7
            finish_transfer();
            expect_eq(half_count, 32, "sclk levels in one transfer");
        end
        end_test("sclk half periods", mark);

        mark = errors;
        next_random(r);
        tx_a = r[15:0];
        load_tx(tx_a);
        launch(r[31:16], 8'd3);
        wb_read(spi_pkg::reg_status, d);
        expect_eq(d[spi_pkg::status_busy_bit], 1'b1, "busy during transfer");
        wb_write(spi_pkg::reg_ctrl, ctrl_word(8'd3, 1'b1));  // Refused start
        next_random(r);
        wb_write(spi_pkg::reg_txdata, r);                    // Refused word
        finish_transfer();
        wb_read(spi_pkg::reg_txdata, d);
        expect_eq(d[15:0], tx_a, "TXDATA after refused write");
        next_random(r);
        launch(r[15:0], 8'd3);  // exp_tx still holds the old word
        finish_transfer();
        end_test("accesses while busy", mark);

        mark = errors;
        next_random(r);
        load_tx(r[15:0]);
        launch(r[31:16], 8'd2);
        wait_idle();
        for (int k = 0; k < 2; k++) begin
            wb_read(spi_pkg::reg_status, d);
            expect_eq(d, 32'h1 << spi_pkg::status_done_bit, "STATUS after transfer");
        end
        finish_transfer();
        wb_read(spi_pkg::reg_status, d);
        expect_eq(d, 32'h0, "STATUS after RXDATA read");
        wb_write(spi_pkg::reg_ctrl, ctrl_word(8'd0, 1'b1));
        wb_read(spi_pkg::reg_status, d);
        expect_eq(d, 32'h0, "STATUS after start with divisor 0");
        end_test("done flag and divisor 0", mark);

        mark = errors;
        for (int i = 0; i < rand_count; i++) begin
            load_tx(rnd_tx[i]);
            launch(rnd_sw[i], rnd_div[i]);
            finish_transfer();
        end
        end_test("random back-to-back transfers", mark);

        $display("%0d of %0d tests passed, %0d checks, %0d errors",
                 tests_passed, tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bench/spi_slave_model.sv */
`timescale 1ns/1ps

module spi_slave_model (
    input  logic                           sclk,
    input  logic                           cs,
    input  logic                           mosi,
    output logic                           miso,
    input  logic [spi_pkg::word_width-1:0] preset,    // Word returned to the master
    output logic [spi_pkg::word_width-1:0] captured   // Word seen on mosi
);

    logic [spi_pkg::word_width-1:0] out_shift;

    initial begin
        miso      = 1'b0;
        out_shift = '0;
        captured  = '0;
    end

    // Reply MSB is on the line as soon as cs falls
    always @(negedge cs) begin
        out_shift <= preset;
        miso      <= preset[spi_pkg::word_width-1];
        captured  <= '0;
    end

    // Mode 0 slave changes its output on the falling edge
    always @(negedge sclk) begin
        if (!cs) begin
            out_shift <= {out_shift[spi_pkg::word_width-2:0], 1'b0};
            miso      <= out_shift[spi_pkg::word_width-2];
        end
    end

    always @(posedge sclk) begin
        if (!cs) begin
            captured <= {captured[spi_pkg::word_width-2:0], mosi};  // MSB arrives first
        end
    end

endmodule

/* design/spi_clock_divider.sv */
`timescale 1ns/1ps

module spi_clock_divider (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic [spi_pkg::div_width-1:0] divisor,
    output logic                          tick
);

    logic [spi_pkg::div_width-1:0] count;

    // Counter sits at zero until the engine leaves idle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count == divisor) begin
            count <= '0;  // Wrap, one half period done
        end else begin
            count <= count + 1'b1;
        end
    end

    // High in the last clock of each half period
    assign tick = (count == divisor);

    // Relies on the engine only ever holding a nonzero divisor
    assert property (@(posedge clk) disable iff (reset) !run |-> !tick)
        else $error("divider ticked while stopped");

endmodule

/* design/spi_master_top.sv */
`timescale 1ns/1ps

module spi_master_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  spi_pkg::reg_addr_t                 wb_adr,
    input  logic [spi_pkg::wb_data_width-1:0]  wb_dat_w,
    input  logic [spi_pkg::wb_sel_width-1:0]   wb_sel,
    output logic [spi_pkg::wb_data_width-1:0]  wb_dat_r,
    output logic                               wb_ack,
    output logic                               sclk,
    output logic                               mosi,
    input  logic                               miso,
    output logic                               cs
);

    spi_pkg::spi_cmd_t cmd;  // Start, word and divisor to the engine
    spi_pkg::spi_rsp_t rsp;  // Busy, done and received word back

    spi_wb_regs u_regs (
        .clk   (clk),
        .reset (reset),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .we    (wb_we),
        .adr   (wb_adr),
        .dat_w (wb_dat_w),
        .sel   (wb_sel),
        .dat_r (wb_dat_r),
        .ack   (wb_ack),
        .cmd   (cmd),
        .rsp   (rsp)
    );

    spi_shift_engine u_engine (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd),
        .rsp   (rsp),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso),
        .cs    (cs)
    );

endmodule

/* design/spi_pkg.sv */
package spi_pkg;

    // Word and bus sizes
    localparam int word_width    = 16;
    localparam int wb_data_width = 32;
    localparam int wb_sel_width  = wb_data_width / 8;
    localparam int div_width     = 8;
    localparam int bit_cnt_width = $clog2(word_width);

    // CTRL fields
    localparam int ctrl_start_bit = 0;  // Write-only, reads as zero
    localparam int ctrl_div_lsb   = 8;  // Divisor in bits 15:8

    // STATUS fields
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

    // Word address of each register, byte offsets 0, 4, 8, 12
    typedef enum logic [1:0] {
        reg_ctrl   = 2'd0,
        reg_txdata = 2'd1,
        reg_rxdata = 2'd2,
        reg_status = 2'd3
    } reg_addr_t;

    // Engine states
    typedef enum logic [1:0] {
        idle,
        select,
        transfer,
        deselect
    } spi_state_t;

    // Register block to engine
    typedef struct packed {
        logic                  start;    // One-cycle pulse
        logic [word_width-1:0] tx_word;
        logic [div_width-1:0]  divisor;  // Half period is divisor+1 clocks
    } spi_cmd_t;

    // Engine to register block
    typedef struct packed {
        logic                  busy;
        logic                  done;     // One-cycle pulse at cs rise
        logic [word_width-1:0] rx_word;
    } spi_rsp_t;

endpackage

/* design/spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic              clk,
    input  logic              reset,
    input  spi_pkg::spi_cmd_t cmd,
    output spi_pkg::spi_rsp_t rsp,
    output logic              sclk,
    output logic              mosi,
    input  logic              miso,
    output logic              cs
);

    spi_pkg::spi_state_t                state;
    logic [spi_pkg::div_width-1:0]      div_q;     // Divisor latched at start
    logic [spi_pkg::word_width-1:0]     tx_shift;  // Bits still to send
    logic [spi_pkg::word_width-1:0]     rx_shift;  // Bits sampled so far
    logic [spi_pkg::bit_cnt_width-1:0]  bit_cnt;   // Falling edges seen
    logic                               done_q;
    logic                               run;
    logic                               tick;
    logic                               last_bit;
    logic                               launch;

    assign run      = (state != spi_pkg::idle);
    assign launch   = (state == spi_pkg::idle) && cmd.start;
    assign last_bit = (bit_cnt == spi_pkg::bit_cnt_width'(spi_pkg::word_width - 1));

    spi_clock_divider u_div (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .divisor (div_q),
        .tick    (tick)
    );

    // State machine and pin drivers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= spi_pkg::idle;
            div_q   <= spi_pkg::div_width'(1);
            bit_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            cs      <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                spi_pkg::idle: begin
                    if (cmd.start) begin
                        state   <= spi_pkg::select;
                        cs      <= 1'b0;
                        mosi    <= cmd.tx_word[spi_pkg::word_width-1];  // MSB first
                        div_q   <= cmd.divisor;
                        bit_cnt <= '0;
                    end
                end
                spi_pkg::select: begin
                    if (tick) begin
                        state <= spi_pkg::transfer;
                        sclk  <= 1'b1;  // First rising edge
                    end
                end
                spi_pkg::transfer: begin
                    if (tick) begin
                        sclk <= ~sclk;
                        if (sclk) begin
                            // Falling edge, move to the next bit
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit) begin
                                state <= spi_pkg::deselect;
                                mosi  <= 1'b0;
                            end else begin
                                mosi <= tx_shift[spi_pkg::word_width-1];
                            end
                        end
                    end
                end
                spi_pkg::deselect: begin
                    if (tick) begin
                        state  <= spi_pkg::idle;
                        cs     <= 1'b1;
                        done_q <= 1'b1;  // Result ready as busy drops
                    end
                end
                default: begin
                    state <= spi_pkg::idle;
                end
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_shift <= {cmd.tx_word[spi_pkg::word_width-2:0], 1'b0};  // Bit 15 already on mosi
        end else if ((state == spi_pkg::transfer) && tick && sclk) begin
            tx_shift <= {tx_shift[spi_pkg::word_width-2:0], 1'b0};
        end

        // Sample on every rising edge, the first comes out of select
        if (tick && !sclk &&
            ((state == spi_pkg::select) || (state == spi_pkg::transfer))) begin
            rx_shift <= {rx_shift[spi_pkg::word_width-2:0], miso};
        end
    end

    assign rsp.busy    = run;
    assign rsp.done    = done_q;
    assign rsp.rx_word = rx_shift;

    // Clock must be parked low before cs is released
    assert property (@(posedge clk) disable iff (reset) cs |-> !sclk)
        else $error("sclk high while deselected");

    // Register block must hold off starts while a transfer runs
    assert property (@(posedge clk) disable iff (reset) cmd.start |-> !rsp.busy)
        else $error("start arrived while busy");

endmodule

/* design/spi_wb_regs.sv */
`timescale 1ns/1ps

module spi_wb_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  spi_pkg::reg_addr_t                   adr,
    input  logic [spi_pkg::wb_data_width-1:0]    dat_w,
    input  logic [spi_pkg::wb_sel_width-1:0]     sel,    // Ignored as every access is a full word
    output logic [spi_pkg::wb_data_width-1:0]    dat_r,
    output logic                                 ack,
    output spi_pkg::spi_cmd_t                    cmd,
    input  spi_pkg::spi_rsp_t                    rsp
);

    logic                                 access;
    logic                                 wr;
    logic                                 rd;
    logic                                 start_req;
    logic                                 start_q;
    logic                                 done_flag;   // Sticky until RXDATA read
    logic [spi_pkg::div_width-1:0]        div_q;
    logic [spi_pkg::div_width-1:0]        new_div;
    logic [spi_pkg::word_width-1:0]       tx_q;
    logic [spi_pkg::word_width-1:0]       rx_q;
    logic [spi_pkg::wb_data_width-1:0]    rd_data;

    // One access per strobe as ack masks the next cycle
    assign access  = cyc && stb && !ack;
    assign wr      = access && we;
    assign rd      = access && !we;
    assign new_div = dat_w[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width];

    // Start only from idle and with a usable divisor
    assign start_req = wr && (adr == spi_pkg::reg_ctrl) && dat_w[spi_pkg::ctrl_start_bit]
                       && !rsp.busy && (new_div != '0);

    always_comb begin
        rd_data = '0;
        case (adr)
            spi_pkg::reg_ctrl: begin
                rd_data[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width] = div_q;
            end
            spi_pkg::reg_txdata: begin
                rd_data[spi_pkg::word_width-1:0] = tx_q;
            end
            spi_pkg::reg_rxdata: begin
                rd_data[spi_pkg::word_width-1:0] = rx_q;
            end
            spi_pkg::reg_status: begin
                rd_data[spi_pkg::status_busy_bit] = rsp.busy;
                rd_data[spi_pkg::status_done_bit] = done_flag;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack       <= 1'b0;
            start_q   <= 1'b0;
            div_q     <= spi_pkg::div_width'(1);
            done_flag <= 1'b0;
        end else begin
            ack     <= access;
            start_q <= start_req;
            if (wr && (adr == spi_pkg::reg_ctrl)) begin
                div_q <= new_div;  // Kept even if the start is refused
            end
            if (rsp.done) begin
                done_flag <= 1'b1;
            end else if (rd && (adr == spi_pkg::reg_rxdata)) begin
                done_flag <= 1'b0;
            end
        end
    end

    // Data registers
    always_ff @(posedge clk) begin
        if (wr && (adr == spi_pkg::reg_txdata) && !rsp.busy) begin
            tx_q <= dat_w[spi_pkg::word_width-1:0];
        end
        if (rsp.done) begin
            rx_q <= rsp.rx_word;
        end
        if (rd) begin
            dat_r <= rd_data;  // Valid alongside ack
        end
    end

    assign cmd.start   = start_q;
    assign cmd.tx_word = tx_q;
    assign cmd.divisor = div_q;

    // Master holds the strobe until it sees ack
    assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
        else $error("ack without a live strobe");

endmodule

/* list.f */
design/spi_pkg.sv
design/spi_clock_divider.sv
design/spi_shift_engine.sv
design/spi_wb_regs.sv
design/spi_master_top.sv
bench/spi_slave_model.sv
bench/spi_master_tb.sv
